/* dcacheTop.f */
hw/dcachePkg.sv
hw/cacheCtrl.sv
hw/tagStore.sv
hw/dataStore.sv
hw/refillBuffer.sv
hw/dcacheTop.sv
tb/dcacheTop_props.sv
tb/dcacheTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcacheTb \
  -f dcacheTop.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
  exit 1
fi
exit 0

/* tb/dcacheTb.sv */
`timescale 1ns/1ns

module dcacheTb;

  localparam int NREQ       = 300;
  localparam int MISS_WORST = 40;
  localparam int MAX_CYCLES = NREQ * MISS_WORST + 200;

  logic                         clk;
  logic                         rst_n;
  logic                         reqValid;
  dcachePkg::cpuReqT            req;
  logic                         reqReady;
  logic                         respValid;
  dcachePkg::wordT              respData;
  logic                         memRdValid;
  logic [dcachePkg::ADDR_W-1:0] memRdAddr;
  logic                         memRdReady;
  logic                         memBeatValid;
  dcachePkg::wordT              memBeatData;
  logic                         memBeatLast;
  logic                         memWrValid;
  logic [dcachePkg::ADDR_W-1:0] memWrAddr;
  dcachePkg::lineT              memWrLine;
  logic                         memWrReady;

  integer seed = 2068;
  int     errors = 0;
  int     loadChecks = 0;
  int     wbChecks = 0;
  int     cycles = 0;

  // backing memory and the processor's view, both keyed by word address
  dcachePkg::wordT memArr [logic [28:0]];
  dcachePkg::wordT refArr [logic [28:0]];
  bit              storedLines [logic [26:0]];

  // in-order expected responses
  dcachePkg::wordT expData [$];
  bit              expLoad [$];

  dcacheTop u_dut (
    .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid), .req_i(req),
    .reqReady_o(reqReady), .respValid_o(respValid), .respData_o(respData),
    .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr), .memRdReady_i(memRdReady),
    .memBeatValid_i(memBeatValid), .memBeatData_i(memBeatData),
    .memBeatLast_i(memBeatLast), .memWrValid_o(memWrValid), .memWrAddr_o(memWrAddr),
    .memWrLine_o(memWrLine), .memWrReady_i(memWrReady)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // untouched memory holds a pattern built from the whole word address
  function automatic dcachePkg::wordT fillWord(logic [28:0] wa);
    return {wa, 3'b101, ~wa, 3'b011};
  endfunction

  function automatic dcachePkg::wordT memRead(logic [28:0] wa);
    return memArr.exists(wa) ? memArr[wa] : fillWord(wa);
  endfunction

  function automatic dcachePkg::wordT refRead(logic [28:0] wa);
    return refArr.exists(wa) ? refArr[wa] : fillWord(wa);
  endfunction

  // byte b lands at byte off+b, anything past byte 7 is lost
  function automatic dcachePkg::wordT applyStore(dcachePkg::wordT old, dcachePkg::wordT data,
                                                 dcachePkg::maskT m, int off);
    dcachePkg::wordT w;
    w = old;
    for (int b = 0; b < 8; b++) begin
      if (m[b] && (off + b) < 8) begin
        w[8*(off+b) +: 8] = data[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic recordAccepted(dcachePkg::cpuReqT r);
    logic [28:0] wa;
    wa = r.addr[31:3];
    if (r.op == dcachePkg::STORE) begin
      refArr[wa] = applyStore(refRead(wa), r.wdata, r.wmask, int'(r.addr[2:0]));
      storedLines[r.addr[31:5]] = 1'b1;
      expLoad.push_back(1'b0);
      expData.push_back('0);
    end else begin
      expLoad.push_back(1'b1);
      expData.push_back(refRead(wa));
    end
  endtask

  task automatic sendReq(dcachePkg::cpuReqT r);
    logic rdy;
    reqValid = 1'b1;
    req      = r;
    do begin
      @(negedge clk);
      rdy = reqReady;
      @(posedge clk);
    end while (!rdy);
    recordAccepted(r);
    #1;
    reqValid = 1'b0;
  endtask

  // response checker, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && respValid) begin
      assert (expLoad.size() > 0) else begin
        $display("response at %0t without an outstanding request", $time);
        errors++;
      end
      if (expLoad.size() > 0) begin
        if (expLoad.pop_front()) begin
          loadChecks++;
          assert (respData == expData[0]) else begin
            $display("[ERROR] %0t respData_o expected %h actual %h", $time, expData[0],
                     respData);
            errors++;
          end
        end
        void'(expData.pop_front());
      end
    end
  end

  // memory model with random grant delays and beat gaps
  initial begin
    int gap;
    logic [28:0] wa;
    memRdReady   = 1'b0;
    memWrReady   = 1'b0;
    memBeatValid = 1'b0;
    memBeatData  = '0;
    memBeatLast  = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && memWrValid) begin
        wa = memWrAddr[31:3];
        wbChecks++;
        assert (storedLines.exists(memWrAddr[31:5])) else begin
          $display("write-back at %0t to line %h that was never stored to", $time, memWrAddr);
          errors++;
        end
        for (int k = 0; k < 4; k++) begin
          assert (memWrLine[64*k +: 64] == refRead(wa + 29'(k))) else begin
            $display("[ERROR] %0t memWrLine_o word %0d expected %h actual %h", $time, k,
                     refRead(wa + 29'(k)), memWrLine[64*k +: 64]);
            errors++;
          end
          memArr[wa + 29'(k)] = memWrLine[64*k +: 64];
        end
        gap = $random(seed) & 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #1 memWrReady = 1'b1;
        @(posedge clk);
        #1 memWrReady = 1'b0;
      end else if (rst_n && memRdValid) begin
        wa = memRdAddr[31:3];
        gap = $random(seed) & 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #1 memRdReady = 1'b1;
        @(posedge clk);
        #1 memRdReady = 1'b0;
        for (int k = 0; k < 4; k++) begin
          gap = $random(seed) & 3;
          repeat (gap) @(posedge clk);
          #1;
          memBeatValid = 1'b1;
          memBeatData  = memRead(wa + 29'(k));
          memBeatLast  = (k == 3);
          @(posedge clk);
          #1;
          memBeatValid = 1'b0;
          memBeatLast  = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses outstanding", cycles,
               expLoad.size());
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    dcachePkg::cpuReqT r;
    logic [31:0] rnd;
    logic [1:0]  tag;
    logic [5:0]  set;
    reqValid = 1'b0;
    req      = '0;
    rst_n    = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    tag = 2'd0;
    set = 6'd0;
    for (int i = 0; i < NREQ; i++) begin
      rnd = $random(seed);
      // half the time stay on the previous line to get hits
      if (rnd[0] || i == 0) begin
        tag = rnd[2:1];
        set = (rnd[5:3] > 3'd3) ? 6'd5 : 6'(rnd[4:3]);
      end
      r.addr  = {19'd0, tag, set, rnd[12:8]};
      // set 5 only ever sees loads
      r.op    = (set != 6'd5 && rnd[6]) ? dcachePkg::STORE : dcachePkg::LOAD;
      r.wdata = {$random(seed), $random(seed)};
      r.wmask = rnd[23:16];
      sendReq(r);
      if (rnd[7] && rnd[13]) begin
        @(posedge clk);
        #1;
      end
    end
    while (expLoad.size() > 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    $display("errors %0d, load checks %0d, write-back checks %0d, cycles %0d", errors,
             loadChecks, wbChecks, cycles);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tb/dcacheTop_props.sv */
`timescale 1ns/1ns

module dcacheTopProps (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         reqValid_i,
  input dcachePkg::cpuReqT            req_i,
  input logic                         reqReady_o,
  input logic                         respValid_o,
  input dcachePkg::cpuReqT            latchedReq_i,
  input logic                         memRdValid_o,
  input logic [dcachePkg::ADDR_W-1:0] memRdAddr_o,
  input logic                         memRdReady_i,
  input logic                         memWrValid_o,
  input logic [dcachePkg::ADDR_W-1:0] memWrAddr_o,
  input logic                         memWrReady_i
);

  // idle outputs while reset is held
  resetState: assert property (@(posedge clk)
    !rst_n |-> reqReady_o && !respValid_o && !memRdValid_o && !memWrValid_o)
    else $error("outputs not in reset state");

  // same line right behind a hit responds next cycle without memory traffic
  backToBackHit: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_o && reqValid_i && reqReady_o &&
    (req_i.addr[31:5] == latchedReq_i.addr[31:5])
    |=> respValid_o && !memRdValid_o && !memWrValid_o)
    else $error("same-line request after a hit did not hit");

  rdHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o && !memRdReady_i |=> memRdValid_o && $stable(memRdAddr_o))
    else $error("memory read request dropped or changed before grant");

  wrHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_o && !memWrReady_i |=> memWrValid_o && $stable(memWrAddr_o))
    else $error("memory write request dropped or changed before grant");

endmodule

bind dcacheTop dcacheTopProps u_props (
  .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid_i), .req_i(req_i),
  .reqReady_o(reqReady_o), .respValid_o(respValid_o), .latchedReq_i(latchedReq),
  .memRdValid_o(memRdValid_o), .memRdAddr_o(memRdAddr_o), .memRdReady_i(memRdReady_i),
  .memWrValid_o(memWrValid_o), .memWrAddr_o(memWrAddr_o), .memWrReady_i(memWrReady_i)
);

/* hw/dcacheTop.sv */
`timescale 1ns/1ns

module dcacheTop (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reqValid_i,
  input  dcachePkg::cpuReqT             req_i,
  output logic                          reqReady_o,
  output logic                          respValid_o,
  output dcachePkg::wordT               respData_o,
  output logic                          memRdValid_o,
  output logic [dcachePkg::ADDR_W-1:0]  memRdAddr_o,
  input  logic                          memRdReady_i,
  input  logic                          memBeatValid_i,
  input  dcachePkg::wordT               memBeatData_i,
  input  logic                          memBeatLast_i,
  output logic                          memWrValid_o,
  output logic [dcachePkg::ADDR_W-1:0]  memWrAddr_o,
  output dcachePkg::lineT               memWrLine_o,
  input  logic                          memWrReady_i
);

  dcachePkg::lookupT  lookup;
  dcachePkg::cpuReqT  latchedReq;
  dcachePkg::fillCmdT fillCmd;
  dcachePkg::lineT    fillLine;
  logic               victimWay;
  logic               refillActive;

  cacheCtrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .req_i          (req_i),
    .reqReady_o     (reqReady_o),
    .respValid_o    (respValid_o),
    .lookup_i       (lookup),
    .latchedReq_o   (latchedReq),
    .victimWay_o    (victimWay),
    .fillCmd_o      (fillCmd),
    .memRdValid_o   (memRdValid_o),
    .memRdAddr_o    (memRdAddr_o),
    .memRdReady_i   (memRdReady_i),
    .memBeatValid_i (memBeatValid_i),
    .memBeatLast_i  (memBeatLast_i),
    .memWrValid_o   (memWrValid_o),
    .memWrAddr_o    (memWrAddr_o),
    .memWrReady_i   (memWrReady_i),
    .refillActive_o (refillActive)
  );

  tagStore u_tags (
    .clk          (clk),
    .rst_n        (rst_n),
    .latchedReq_i (latchedReq),
    .victimWay_i  (victimWay),
    .fillCmd_i    (fillCmd),
    .lookup_o     (lookup)
  );

  dataStore u_data (
    .clk          (clk),
    .latchedReq_i (latchedReq),
    .hitWay_i     (lookup.hitWay),
    .victimWay_i  (victimWay),
    .fillCmd_i    (fillCmd),
    .fillLine_i   (fillLine),
    .rdWord_o     (respData_o),
    .evictLine_o  (memWrLine_o)
  );

  refillBuffer u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .beatValid_i (refillActive),
    .beatData_i  (memBeatData_i),
    .line_o      (fillLine)
  );

endmodule

/* hw/refillBuffer.sv */
`timescale 1ns/1ns

module refillBuffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             beatValid_i,
  input  dcachePkg::wordT  beatData_i,
  output dcachePkg::lineT  line_o
);

  logic [$clog2(dcachePkg::BEATS)-1:0] beatCnt;
  dcachePkg::lineT                     lineBuf;

  // wraps to zero after the last beat of a line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beats arrive lowest word first
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineBuf[beatCnt*dcachePkg::XLEN +: dcachePkg::XLEN] <= beatData_i;
    end
  end

  assign line_o = lineBuf;

endmodule

/* hw/dataStore.sv */
`timescale 1ns/1ns

module dataStore (
  input  logic                clk,
  input  dcachePkg::cpuReqT   latchedReq_i,
  input  logic                hitWay_i,
  input  logic                victimWay_i,
  input  dcachePkg::fillCmdT  fillCmd_i,
  input  dcachePkg::lineT     fillLine_i,
  output dcachePkg::wordT     rdWord_o,
  output dcachePkg::lineT     evictLine_o
);

  dcachePkg::lineT  lines [dcachePkg::WAYS][dcachePkg::SETS];

  dcachePkg::indexT index;
  logic [dcachePkg::OFFSET_W-4:0] wordSel;
  logic [2:0]       byteOff;
  dcachePkg::lineT  hitLine;
  dcachePkg::wordT  shData;
  dcachePkg::maskT  shMask;
  dcachePkg::wordT  bitMask;
  dcachePkg::wordT  mergedWord;

  assign index   = latchedReq_i.addr[dcachePkg::OFFSET_W +: dcachePkg::INDEX_W];
  assign wordSel = latchedReq_i.addr[dcachePkg::OFFSET_W-1:3];
  assign byteOff = latchedReq_i.addr[2:0];

  // word of the hit way
  assign hitLine  = lines[hitWay_i][index];
  assign rdWord_o = hitLine[wordSel*dcachePkg::XLEN +: dcachePkg::XLEN];

  // line leaving the cache on a dirty miss
  assign evictLine_o = lines[victimWay_i][index];

  // bytes shifted past the top of the word fall off
  assign shData = latchedReq_i.wdata << {byteOff, 3'b000};
  assign shMask = latchedReq_i.wmask << byteOff;

  always_comb begin
    for (int b = 0; b < dcachePkg::XLEN/8; b++) begin
      bitMask[8*b +: 8] = {8{shMask[b]}};
    end
  end

  assign mergedWord = (rdWord_o & ~bitMask) | (shData & bitMask);

  always_ff @(posedge clk) begin
    if (fillCmd_i.refill) begin
      lines[fillCmd_i.way][index] <= fillLine_i;
    end else if (fillCmd_i.storeHit) begin
      lines[fillCmd_i.way][index][wordSel*dcachePkg::XLEN +: dcachePkg::XLEN] <= mergedWord;
    end
  end

endmodule

/* hw/tagStore.sv */
`timescale 1ns/1ns

module tagStore (
  input  logic                clk,
  input  logic                rst_n,
  input  dcachePkg::cpuReqT   latchedReq_i,
  input  logic                victimWay_i,
  input  dcachePkg::fillCmdT  fillCmd_i,
  output dcachePkg::lookupT   lookup_o
);

  dcachePkg::tagT   tagArr [dcachePkg::WAYS][dcachePkg::SETS];
  logic [dcachePkg::WAYS-1:0][dcachePkg::SETS-1:0] validBits;
  logic [dcachePkg::WAYS-1:0][dcachePkg::SETS-1:0] dirtyBits;

  dcachePkg::indexT index;
  dcachePkg::tagT   reqTag;
  logic [dcachePkg::WAYS-1:0] wayHit;

  assign index  = latchedReq_i.addr[dcachePkg::OFFSET_W +: dcachePkg::INDEX_W];
  assign reqTag = latchedReq_i.addr[dcachePkg::ADDR_W-1 -: dcachePkg::TAG_W];

  // compare both ways
  always_comb begin
    for (int w = 0; w < dcachePkg::WAYS; w++) begin
      wayHit[w] = validBits[w][index] && (tagArr[w][index] == reqTag);
    end
  end

  always_comb begin
    lookup_o.hit         = |wayHit;
    lookup_o.hitWay      = wayHit[1];
    // an invalid victim never needs a write-back
    lookup_o.victimDirty = validBits[victimWay_i][index] && dirtyBits[victimWay_i][index];
    lookup_o.victimTag   = tagArr[victimWay_i][index];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (fillCmd_i.refill) begin
      validBits[fillCmd_i.way][index] <= 1'b1;
      dirtyBits[fillCmd_i.way][index] <= 1'b0;
    end else if (fillCmd_i.storeHit) begin
      dirtyBits[fillCmd_i.way][index] <= 1'b1;
    end
  end

  // new tag goes in with the refilled line
  always_ff @(posedge clk) begin
    if (fillCmd_i.refill) begin
      tagArr[fillCmd_i.way][index] <= reqTag;
    end
  end

endmodule

/* hw/cacheCtrl.sv */
`timescale 1ns/1ns

module cacheCtrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             reqValid_i,
  input  dcachePkg::cpuReqT                req_i,
  output logic                             reqReady_o,
  output logic                             respValid_o,
  input  dcachePkg::lookupT                lookup_i,
  output dcachePkg::cpuReqT                latchedReq_o,
  output logic                             victimWay_o,
  output dcachePkg::fillCmdT               fillCmd_o,
  output logic                             memRdValid_o,
  output logic [dcachePkg::ADDR_W-1:0]     memRdAddr_o,
  input  logic                             memRdReady_i,
  input  logic                             memBeatValid_i,
  input  logic                             memBeatLast_i,
  output logic                             memWrValid_o,
  output logic [dcachePkg::ADDR_W-1:0]     memWrAddr_o,
  input  logic                             memWrReady_i,
  output logic                             refillActive_o
);

  dcachePkg::cacheStateE state;
  dcachePkg::cacheStateE nextState;
  dcachePkg::cpuReqT     reqLatch;
  dcachePkg::indexT      index;
  logic [7:0]            lfsr;
  logic                  lfsrFb;
  logic                  victimReg;
  logic                  accept;
  logic                  compareHit;
  logic                  compareMiss;

  assign compareHit  = (state == dcachePkg::COMPARE) && lookup_i.hit;
  assign compareMiss = (state == dcachePkg::COMPARE) && !lookup_i.hit;

  // ready while idle or while the current request is hitting
  assign reqReady_o  = (state == dcachePkg::IDLE) || compareHit;
  assign accept      = reqValid_i && reqReady_o;
  assign respValid_o = compareHit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcachePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::IDLE: begin
        if (accept) begin
          nextState = dcachePkg::COMPARE;
        end
      end
      dcachePkg::COMPARE: begin
        if (lookup_i.hit) begin
          nextState = accept ? dcachePkg::COMPARE : dcachePkg::IDLE;
        end else if (lookup_i.victimDirty) begin
          nextState = dcachePkg::WRBACK;
        end else begin
          nextState = dcachePkg::MISS;
        end
      end
      dcachePkg::WRBACK: begin
        if (memWrReady_i) begin
          nextState = dcachePkg::MISS;
        end
      end
      dcachePkg::MISS: begin
        if (memRdReady_i) begin
          nextState = dcachePkg::GETDATA;
        end
      end
      dcachePkg::GETDATA: begin
        if (memBeatValid_i && memBeatLast_i) begin
          nextState = dcachePkg::REFILL;
        end
      end
      dcachePkg::REFILL: begin
        // retry the latched request, it hits now
        nextState = dcachePkg::COMPARE;
      end
      default: begin
        nextState = dcachePkg::IDLE;
      end
    endcase
  end

  // request payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= req_i;
    end
  end

  assign latchedReq_o = reqLatch;
  assign index = reqLatch.addr[dcachePkg::OFFSET_W +: dcachePkg::INDEX_W];

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsrFb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr      <= dcachePkg::LFSR_SEED;
      victimReg <= 1'b0;
    end else if (compareMiss) begin
      lfsr      <= {lfsr[6:0], lfsrFb};
      victimReg <= lfsr[0];
    end
  end

  // live choice during compare so the dirty check sees the same way
  assign victimWay_o = (state == dcachePkg::COMPARE) ? lfsr[0] : victimReg;

  always_comb begin
    fillCmd_o.refill   = (state == dcachePkg::REFILL);
    fillCmd_o.storeHit = compareHit && (reqLatch.op == dcachePkg::STORE);
    fillCmd_o.way      = fillCmd_o.refill ? victimReg : lookup_i.hitWay;
  end

  // memory requests held by state until granted
  assign memWrValid_o = (state == dcachePkg::WRBACK);
  assign memWrAddr_o  = {lookup_i.victimTag, index, {dcachePkg::OFFSET_W{1'b0}}};
  assign memRdValid_o = (state == dcachePkg::MISS);
  assign memRdAddr_o  = {reqLatch.addr[dcachePkg::ADDR_W-1:dcachePkg::OFFSET_W],
                         {dcachePkg::OFFSET_W{1'b0}}};

  // beat strobe for the line buffer
  assign refillActive_o = (state == dcachePkg::GETDATA) && memBeatValid_i;

endmodule

/* hw/dcachePkg.sv */
package dcachePkg;

  // geometry
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;
  localparam int WAYS     = 2;
  localparam int SETS     = 64;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int BEATS    = 4;
  localparam int LINE_W   = BEATS * XLEN;

  // victim lfsr start value, must be nonzero
  localparam logic [7:0] LFSR_SEED = 8'hB5;

  typedef logic [XLEN-1:0]    wordT;
  typedef logic [LINE_W-1:0]  lineT;
  typedef logic [TAG_W-1:0]   tagT;
  typedef logic [INDEX_W-1:0] indexT;
  typedef logic [XLEN/8-1:0]  maskT;

  typedef enum logic {
    LOAD,
    STORE
  } memOpE;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRBACK,
    MISS,
    GETDATA,
    REFILL
  } cacheStateE;

  typedef struct packed {
    memOpE              op;
    logic [ADDR_W-1:0]  addr;
    wordT               wdata;
    maskT               wmask;
  } cpuReqT;

  // tag side result for the latched request
  typedef struct packed {
    logic hit;
    logic hitWay;
    logic victimDirty;
    tagT  victimTag;
  } lookupT;

  // array write command, refill wins over store hit
  typedef struct packed {
    logic refill;
    logic storeHit;
    logic way;
  } fillCmdT;

endpackage
